/* valagaPkg.sv */
package valagaPkg;

    // Screen coordinates
    typedef logic [9:0] coordX_t;
    typedef logic [8:0] coordY_t;

    // Top-left corner of an object
    typedef struct packed {
        coordX_t x;
        coordY_t y;
    } objPos_t;

    typedef enum logic [1:0] {
        GameIdle,
        GamePlaying,
        GameVictory
    } gameState_t;

    // Value of a lit colour channel
    localparam logic [7:0] ColorFull = 8'hFF;

endpackage

/* objectIf.sv */
`timescale 1ns/1ps

interface objectIf #(
    parameter int MaxBullets = 4,
    parameter int EnemyCount = 15
);
    import valagaPkg::*;

    objPos_t               playerPos;
    objPos_t               bulletPos [MaxBullets];
    logic [MaxBullets-1:0] bulletAlive;
    objPos_t               enemyPos [EnemyCount];
    logic [EnemyCount-1:0] enemyAlive;

    // Player and its bullets
    modport playerSide (
        output playerPos,
        output bulletPos,
        output bulletAlive
    );

    modport enemySide (
        output enemyPos,
        output enemyAlive
    );

    // Collision and drawing only look
    modport viewer (
        input playerPos,
        input bulletPos,
        input bulletAlive,
        input enemyPos,
        input enemyAlive
    );

endinterface

/* vgaTiming.sv */
`timescale 1ns/1ps

module vgaTiming #(
    parameter int HDisplay = 640,
    parameter int HTotal   = 800,
    parameter int VDisplay = 480,
    parameter int VTotal   = 525
) (
    input  logic               o_Clk,
    input  logic               i_rstN,
    output valagaPkg::coordX_t o_pixelX,
    output valagaPkg::coordY_t o_pixelY,
    output logic               o_frameTick
);
    import valagaPkg::*;

    coordX_t    xCnt;
    logic [9:0] yCnt;

    always_ff @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            xCnt <= '0;
            yCnt <= '0;
        end else if (int'(xCnt) == HTotal - 1) begin
            xCnt <= '0;
            if (int'(yCnt) == VTotal - 1) begin
                yCnt <= '0;
            end else begin
                yCnt <= yCnt + 1'b1;
            end
        end else begin
            xCnt <= xCnt + 1'b1;
        end
    end

    assign o_pixelX = xCnt;

    // Lines from 511 on lie past the visible and sync ranges
    assign o_pixelY = (yCnt > 10'd510) ? '1 : yCnt[8:0];

    // Last visible pixel paces the game
    assign o_frameTick = (int'(xCnt) == HDisplay - 1) && (int'(yCnt) == VDisplay - 1);

endmodule

/* buttonConditioner.sv */
`timescale 1ns/1ps

module buttonConditioner (
    input  logic       o_Clk,
    input  logic       i_rstN,
    input  logic [3:0] i_Btn,
    output logic       o_startPress,
    output logic       o_firePress,
    output logic       o_leftHeld,
    output logic       o_rightHeld
);
    // Buttons inverted to active high on entry
    logic [3:0] syncA;
    logic [3:0] syncB;
    logic [1:0] pressPrev;

    always_ff @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            syncA        <= '0;
            syncB        <= '0;
            pressPrev    <= '0;
            o_startPress <= 1'b0;
            o_firePress  <= 1'b0;
        end else begin
            syncA        <= ~i_Btn;
            syncB        <= syncA;
            pressPrev    <= syncB[1:0];
            o_startPress <= syncB[0] & ~pressPrev[0];
            o_firePress  <= syncB[1] & ~pressPrev[1];
        end
    end

    assign o_leftHeld  = syncB[3];
    assign o_rightHeld = syncB[2];

endmodule

/* gameControl.sv */
`timescale 1ns/1ps

module gameControl #(
    parameter int EnemyCount = 15
) (
    input  logic                  o_Clk,
    input  logic                  i_rstN,
    input  logic                  i_startPress,
    input  logic [EnemyCount-1:0] i_enemyAlive,
    output valagaPkg::gameState_t o_state,
    output logic                  o_newGame
);
    import valagaPkg::*;

    always_ff @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_state   <= GameIdle;
            o_newGame <= 1'b0;
        end else begin
            o_newGame <= 1'b0;
            case (o_state)
                GameIdle: begin
                    if (i_startPress) begin
                        o_state   <= GamePlaying;
                        o_newGame <= 1'b1;
                    end
                end
                GamePlaying: begin
                    if (i_startPress) begin
                        o_state <= GameIdle;
                    // Mask is stale while the units reload
                    end else if (!o_newGame && i_enemyAlive == '0) begin
                        o_state <= GameVictory;
                    end
                end
                GameVictory: begin
                    if (i_startPress) begin
                        o_state <= GameIdle;
                    end
                end
                default: o_state <= GameIdle;
            endcase
        end
    end

endmodule

/* playerUnit.sv */
`timescale 1ns/1ps

module playerUnit #(
    parameter int HDisplay    = 640,
    parameter int PlayerW     = 32,
    parameter int PlayerY     = 440,
    parameter int PlayerSpeed = 4,
    parameter int BulletH     = 8,
    parameter int BulletSpeed = 8,
    parameter int MaxBullets  = 4,
    parameter int CoolDown    = 11
) (
    input  logic                  o_Clk,
    input  logic                  i_rstN,
    input  logic                  i_frameTick,
    input  valagaPkg::gameState_t i_state,
    input  logic                  i_newGame,
    input  logic                  i_firePress,
    input  logic                  i_leftHeld,
    input  logic                  i_rightHeld,
    input  logic [MaxBullets-1:0] i_bulletKill,
    objectIf.playerSide           o_objs
);
    import valagaPkg::*;

    localparam coordX_t StartX  = coordX_t'((HDisplay - PlayerW) / 2);
    localparam coordX_t MaxX    = coordX_t'(HDisplay - PlayerW);
    localparam coordX_t StepX   = coordX_t'(PlayerSpeed);
    localparam coordX_t MuzzleX = coordX_t'(PlayerW / 2);
    localparam coordY_t BaseY   = coordY_t'(PlayerY);
    localparam coordY_t SpawnY  = coordY_t'(PlayerY - BulletH);
    localparam coordY_t StepY   = coordY_t'(BulletSpeed);
    localparam int      CoolW   = $clog2(CoolDown + 2);

    logic [CoolW-1:0]      coolCnt;
    logic                  fireLatch;
    logic                  fireNow;
    logic                  step;
    logic [MaxBullets-1:0] freeMask;
    logic [MaxBullets-1:0] spawnSel;

    assign step     = i_frameTick && (i_state == GamePlaying);
    assign freeMask = ~o_objs.bulletAlive;
    assign fireNow  = (fireLatch || i_firePress) && (coolCnt == '0) && (|freeMask);

    // Lowest free slot, one-hot
    assign spawnSel = fireNow ? (freeMask & (~freeMask + 1'b1)) : '0;

    // ############################
    // Player, slots and cooldown
    always_ff @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_objs.playerPos   <= '{x: StartX, y: BaseY};
            o_objs.bulletAlive <= '0;
            coolCnt            <= '0;
            fireLatch          <= 1'b0;
        end else if (i_newGame) begin
            o_objs.playerPos   <= '{x: StartX, y: BaseY};
            o_objs.bulletAlive <= '0;
            coolCnt            <= '0;
            fireLatch          <= 1'b0;
        end else begin
            fireLatch <= !i_frameTick && (fireLatch || i_firePress);
            if (step) begin
                if (i_leftHeld) begin
                    o_objs.playerPos.x <= (o_objs.playerPos.x < StepX) ?
                                          '0 : o_objs.playerPos.x - StepX;
                end else if (i_rightHeld) begin
                    o_objs.playerPos.x <= (o_objs.playerPos.x + StepX > MaxX) ?
                                          MaxX : o_objs.playerPos.x + StepX;
                end
                if (fireNow) begin
                    coolCnt <= CoolW'(CoolDown);
                end else if (coolCnt != '0) begin
                    coolCnt <= coolCnt - 1'b1;
                end
                for (int i = 0; i < MaxBullets; i++) begin
                    if (spawnSel[i]) begin
                        o_objs.bulletAlive[i] <= 1'b1;
                    end else if (i_bulletKill[i] || o_objs.bulletPos[i].y < StepY) begin
                        o_objs.bulletAlive[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Bullets rise, new ones leave the muzzle
    always_ff @(posedge o_Clk) begin
        if (step) begin
            for (int i = 0; i < MaxBullets; i++) begin
                if (spawnSel[i]) begin
                    o_objs.bulletPos[i] <= '{x: o_objs.playerPos.x + MuzzleX, y: SpawnY};
                end else begin
                    o_objs.bulletPos[i].y <= o_objs.bulletPos[i].y - StepY;
                end
            end
        end
    end

endmodule

/* enemyFormation.sv */
`timescale 1ns/1ps

module enemyFormation #(
    parameter int EnemyW       = 24,
    parameter int EnemyH       = 16,
    parameter int EnemyCols    = 5,
    parameter int EnemyRows    = 3,
    parameter int EnemyGapX    = 16,
    parameter int EnemyGapY    = 16,
    parameter int EnemyOriginX = 200,
    parameter int EnemyOriginY = 60,
    parameter int PhaseLen     = 64
) (
    input  logic                               o_Clk,
    input  logic                               i_rstN,
    input  logic                               i_frameTick,
    input  valagaPkg::gameState_t              i_state,
    input  logic                               i_newGame,
    input  logic [EnemyCols*EnemyRows-1:0]     i_enemyKill,
    objectIf.enemySide                         o_objs
);
    import valagaPkg::*;

    localparam int EnemyCount = EnemyCols * EnemyRows;
    localparam int PhaseW     = $clog2(PhaseLen + 1);

    logic [PhaseW-1:0] phaseCnt;
    logic              swayRight;
    logic              step;

    assign step = i_frameTick && (i_state == GamePlaying);

    // ############################
    // Sway phase and alive mask
    always_ff @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            phaseCnt          <= '0;
            swayRight         <= 1'b1;
            o_objs.enemyAlive <= '0;
        end else if (i_newGame) begin
            phaseCnt          <= '0;
            swayRight         <= 1'b1;
            o_objs.enemyAlive <= {EnemyCount{1'b1}};
        end else if (step) begin
            o_objs.enemyAlive <= o_objs.enemyAlive & ~i_enemyKill;
            if (int'(phaseCnt) == PhaseLen - 1) begin
                phaseCnt  <= '0;
                swayRight <= !swayRight;
            end else begin
                phaseCnt <= phaseCnt + 1'b1;
            end
        end
    end

    // Grid placement, rows sway in turn
    always_ff @(posedge o_Clk) begin
        for (int r = 0; r < EnemyRows; r++) begin
            for (int c = 0; c < EnemyCols; c++) begin
                if (i_newGame) begin
                    o_objs.enemyPos[r * EnemyCols + c] <= '{
                        x: coordX_t'(EnemyOriginX + c * (EnemyW + EnemyGapX)),
                        y: coordY_t'(EnemyOriginY + r * (EnemyH + EnemyGapY))
                    };
                end else if (step) begin
                    if (swayRight ^ r[0]) begin
                        o_objs.enemyPos[r * EnemyCols + c].x <=
                            o_objs.enemyPos[r * EnemyCols + c].x + 1'b1;
                    end else begin
                        o_objs.enemyPos[r * EnemyCols + c].x <=
                            o_objs.enemyPos[r * EnemyCols + c].x - 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hitDetect.sv */
`timescale 1ns/1ps

module hitDetect #(
    parameter int BulletW    = 2,
    parameter int BulletH    = 8,
    parameter int EnemyW     = 24,
    parameter int EnemyH     = 16,
    parameter int MaxBullets = 4,
    parameter int EnemyCount = 15
) (
    objectIf.viewer               i_objs,
    output logic [MaxBullets-1:0] o_bulletKill,
    output logic [EnemyCount-1:0] o_enemyKill
);
    import valagaPkg::*;

    // Edges that only touch do not count
    function automatic logic overlaps(objPos_t a, int aw, int ah, objPos_t b, int bw, int bh);
        return (int'(a.x) < int'(b.x) + bw) && (int'(b.x) < int'(a.x) + aw) &&
               (int'(a.y) < int'(b.y) + bh) && (int'(b.y) < int'(a.y) + ah);
    endfunction

    always_comb begin
        o_bulletKill = '0;
        o_enemyKill  = '0;
        for (int b = 0; b < MaxBullets; b++) begin
            for (int e = 0; e < EnemyCount; e++) begin
                if (i_objs.bulletAlive[b] && i_objs.enemyAlive[e] &&
                    overlaps(i_objs.bulletPos[b], BulletW, BulletH,
                             i_objs.enemyPos[e], EnemyW, EnemyH)) begin
                    o_bulletKill[b] = 1'b1;
                    o_enemyKill[e]  = 1'b1;
                end
            end
        end
    end

endmodule

/* pixelRenderer.sv */
`timescale 1ns/1ps

module pixelRenderer #(
    parameter int HDisplay   = 640,
    parameter int HSyncStart = 656,
    parameter int HSyncEnd   = 752,
    parameter int VDisplay   = 480,
    parameter int VSyncStart = 490,
    parameter int VSyncEnd   = 492,
    parameter int PlayerW    = 32,
    parameter int PlayerH    = 16,
    parameter int BulletW    = 2,
    parameter int BulletH    = 8,
    parameter int EnemyW     = 24,
    parameter int EnemyH     = 16,
    parameter int MaxBullets = 4,
    parameter int EnemyCount = 15
) (
    input  logic               o_Clk,
    input  logic               i_rstN,
    input  valagaPkg::coordX_t i_pixelX,
    input  valagaPkg::coordY_t i_pixelY,
    objectIf.viewer            i_objs,
    output logic [7:0]         o_Red,
    output logic [7:0]         o_Green,
    output logic [7:0]         o_Blue,
    output logic               o_hsync,
    output logic               o_vsync,
    output logic               o_blank
);
    import valagaPkg::*;

    logic visible;
    logic inHSync;
    logic inVSync;
    logic playerPix;
    logic bulletPix;
    logic enemyPix;

    function automatic logic inRect(objPos_t pos, int w, int h, coordX_t px, coordY_t py);
        return (px >= pos.x) && (int'(px) < int'(pos.x) + w) &&
               (py >= pos.y) && (int'(py) < int'(pos.y) + h);
    endfunction

    assign visible = (int'(i_pixelX) < HDisplay) && (int'(i_pixelY) < VDisplay);
    assign inHSync = (int'(i_pixelX) >= HSyncStart) && (int'(i_pixelX) < HSyncEnd);
    assign inVSync = (int'(i_pixelY) >= VSyncStart) && (int'(i_pixelY) < VSyncEnd);

    // Player has no alive bit
    assign playerPix = inRect(i_objs.playerPos, PlayerW, PlayerH, i_pixelX, i_pixelY);

    always_comb begin
        bulletPix = 1'b0;
        enemyPix  = 1'b0;
        for (int b = 0; b < MaxBullets; b++) begin
            bulletPix |= i_objs.bulletAlive[b] &&
                         inRect(i_objs.bulletPos[b], BulletW, BulletH, i_pixelX, i_pixelY);
        end
        for (int e = 0; e < EnemyCount; e++) begin
            enemyPix |= i_objs.enemyAlive[e] &&
                        inRect(i_objs.enemyPos[e], EnemyW, EnemyH, i_pixelX, i_pixelY);
        end
    end

    // ############################
    // Video out, one pixel late
    always_ff @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_Red   <= '0;
            o_Green <= '0;
            o_Blue  <= '0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_blank <= 1'b0;
        end else begin
            o_hsync <= !inHSync;
            o_vsync <= !inVSync;
            o_blank <= visible;
            o_Blue  <= (visible && playerPix) ? ColorFull : '0;
            o_Green <= (visible && !playerPix && bulletPix) ? ColorFull : '0;
            o_Red   <= (visible && !playerPix && !bulletPix && enemyPix) ? ColorFull : '0;
        end
    end

endmodule

/* valagaTop.sv */
`timescale 1ns/1ps

module valagaTop #(
    parameter int HDisplay     = 640,
    parameter int HSyncStart   = 656,
    parameter int HSyncEnd     = 752,
    parameter int HTotal       = 800,
    parameter int VDisplay     = 480,
    parameter int VSyncStart   = 490,
    parameter int VSyncEnd     = 492,
    parameter int VTotal       = 525,
    parameter int PlayerW      = 32,
    parameter int PlayerH      = 16,
    parameter int PlayerY      = 440,
    parameter int PlayerSpeed  = 4,
    parameter int BulletW      = 2,
    parameter int BulletH      = 8,
    parameter int BulletSpeed  = 8,
    parameter int MaxBullets   = 4,
    parameter int CoolDown     = 11,
    parameter int EnemyW       = 24,
    parameter int EnemyH       = 16,
    parameter int EnemyCols    = 5,
    parameter int EnemyRows    = 3,
    parameter int EnemyGapX    = 16,
    parameter int EnemyGapY    = 16,
    parameter int EnemyOriginX = 200,
    parameter int EnemyOriginY = 60,
    parameter int PhaseLen     = 64
) (
    input  logic       o_Clk,
    input  logic       i_rstN,
    input  logic [3:0] i_Btn,
    output logic [7:0] o_Red,
    output logic [7:0] o_Green,
    output logic [7:0] o_Blue,
    output logic       o_hsync,
    output logic       o_vsync,
    output logic       o_blank,
    output logic [1:0] o_GameState
);
    import valagaPkg::*;

    localparam int EnemyCount = EnemyCols * EnemyRows;

    coordX_t               pixelX;
    coordY_t               pixelY;
    logic                  frameTick;
    logic                  startPress;
    logic                  firePress;
    logic                  leftHeld;
    logic                  rightHeld;
    gameState_t            gameState;
    logic                  newGame;
    logic [MaxBullets-1:0] bulletKill;
    logic [EnemyCount-1:0] enemyKill;

    objectIf #(.MaxBullets(MaxBullets), .EnemyCount(EnemyCount)) objs ();

    assign o_GameState = gameState;

    // ############################
    // Timing and inputs
    vgaTiming #(
        .HDisplay(HDisplay), .HTotal(HTotal),
        .VDisplay(VDisplay), .VTotal(VTotal)
    ) vgaTiming_i (
        .o_Clk       (o_Clk),
        .i_rstN      (i_rstN),
        .o_pixelX    (pixelX),
        .o_pixelY    (pixelY),
        .o_frameTick (frameTick)
    );

    buttonConditioner buttonConditioner_i (
        .o_Clk        (o_Clk),
        .i_rstN       (i_rstN),
        .i_Btn        (i_Btn),
        .o_startPress (startPress),
        .o_firePress  (firePress),
        .o_leftHeld   (leftHeld),
        .o_rightHeld  (rightHeld)
    );

    gameControl #(.EnemyCount(EnemyCount)) gameControl_i (
        .o_Clk        (o_Clk),
        .i_rstN       (i_rstN),
        .i_startPress (startPress),
        .i_enemyAlive (objs.enemyAlive),
        .o_state      (gameState),
        .o_newGame    (newGame)
    );

    // ############################
    // Game objects
    playerUnit #(
        .HDisplay(HDisplay), .PlayerW(PlayerW), .PlayerY(PlayerY),
        .PlayerSpeed(PlayerSpeed), .BulletH(BulletH), .BulletSpeed(BulletSpeed),
        .MaxBullets(MaxBullets), .CoolDown(CoolDown)
    ) playerUnit_i (
        .o_Clk        (o_Clk),
        .i_rstN       (i_rstN),
        .i_frameTick  (frameTick),
        .i_state      (gameState),
        .i_newGame    (newGame),
        .i_firePress  (firePress),
        .i_leftHeld   (leftHeld),
        .i_rightHeld  (rightHeld),
        .i_bulletKill (bulletKill),
        .o_objs       (objs.playerSide)
    );

    enemyFormation #(
        .EnemyW(EnemyW), .EnemyH(EnemyH), .EnemyCols(EnemyCols), .EnemyRows(EnemyRows),
        .EnemyGapX(EnemyGapX), .EnemyGapY(EnemyGapY),
        .EnemyOriginX(EnemyOriginX), .EnemyOriginY(EnemyOriginY), .PhaseLen(PhaseLen)
    ) enemyFormation_i (
        .o_Clk       (o_Clk),
        .i_rstN      (i_rstN),
        .i_frameTick (frameTick),
        .i_state     (gameState),
        .i_newGame   (newGame),
        .i_enemyKill (enemyKill),
        .o_objs      (objs.enemySide)
    );

    hitDetect #(
        .BulletW(BulletW), .BulletH(BulletH), .EnemyW(EnemyW), .EnemyH(EnemyH),
        .MaxBullets(MaxBullets), .EnemyCount(EnemyCount)
    ) hitDetect_i (
        .i_objs       (objs.viewer),
        .o_bulletKill (bulletKill),
        .o_enemyKill  (enemyKill)
    );

    pixelRenderer #(
        .HDisplay(HDisplay), .HSyncStart(HSyncStart), .HSyncEnd(HSyncEnd),
        .VDisplay(VDisplay), .VSyncStart(VSyncStart), .VSyncEnd(VSyncEnd),
        .PlayerW(PlayerW), .PlayerH(PlayerH), .BulletW(BulletW), .BulletH(BulletH),
        .EnemyW(EnemyW), .EnemyH(EnemyH), .MaxBullets(MaxBullets), .EnemyCount(EnemyCount)
    ) pixelRenderer_i (
        .o_Clk    (o_Clk),
        .i_rstN   (i_rstN),
        .i_pixelX (pixelX),
        .i_pixelY (pixelY),
        .i_objs   (objs.viewer),
        .o_Red    (o_Red),
        .o_Green  (o_Green),
        .o_Blue   (o_Blue),
        .o_hsync  (o_hsync),
        .o_vsync  (o_vsync),
        .o_blank  (o_blank)
    );

endmodule

/* valagaChecker.sv */
`timescale 1ns/1ps

module valagaChecker #(
    parameter int HDisplay   = 40,
    parameter int HSyncStart = 42,
    parameter int HSyncEnd   = 44,
    parameter int HTotal     = 48,
    parameter int VDisplay   = 24,
    parameter int VSyncStart = 25,
    parameter int VSyncEnd   = 26,
    parameter int VTotal     = 28,
    parameter int EnemyArea  = 8
) (
    input  logic       o_Clk,
    input  logic       i_rstN,
    input  logic [7:0] i_red,
    input  logic [7:0] i_green,
    input  logic [7:0] i_blue,
    input  logic       i_hsync,
    input  logic       i_vsync,
    input  logic       i_blank,
    input  logic [1:0] i_state,
    input  logic       i_checkEn,
    input  logic       i_huntMode,
    input  int         i_expState,
    input  int         i_expBlue,
    input  int         i_expGreen,
    input  int         i_expRed,
    input  int         i_expBlueX,
    input  int         i_expDBlueX,
    input  int         i_expDGreenY,
    output int         o_frameCount,
    output int         o_errors,
    output int         o_blueMinX,
    output int         o_redMinX,
    output int         o_state
);
    localparam int NoDelta = 99;
    localparam int Far     = 9999;

    int   x;
    int   y;
    int   frames;
    int   errors;
    logic aligned;
    int   blueCnt;
    int   greenCnt;
    int   redCnt;
    int   blueMinX;
    int   redMinX;
    int   greenMinY;
    int   prevBlueX;
    int   prevGreenY;
    int   cleanRed;

    task automatic mismatch(input string what, input int got, input int exp);
        $display("MISMATCH at %0t: frame %0d %s got %0d expected %0d",
                 $time, frames, what, got, exp);
        errors++;
    endtask

    task automatic compareVal(input string what, input int got, input int exp);
        if (exp >= 0 && got != exp) begin
            mismatch(what, got, exp);
        end
    endtask

    // ############################
    // Per-pixel sync and colour rules
    task automatic checkPixel();
        logic vis;
        logic hsExp;
        logic vsExp;
        vis   = (x < HDisplay) && (y < VDisplay);
        hsExp = !(x >= HSyncStart && x < HSyncEnd);
        vsExp = !(y >= VSyncStart && y < VSyncEnd);
        if (i_hsync !== hsExp) mismatch("hsync", i_hsync, hsExp);
        if (i_vsync !== vsExp) mismatch("vsync", i_vsync, vsExp);
        if (i_blank !== vis) mismatch("blank", i_blank, vis);
        if (!vis && (i_red | i_green | i_blue) != 0) begin
            mismatch("colour outside", i_red | i_green | i_blue, 0);
        end
        // A lit channel is always at full level
        if ((i_red != 8'h00 && i_red != 8'hFF) || (i_green != 8'h00 && i_green != 8'hFF) ||
            (i_blue != 8'h00 && i_blue != 8'hFF)) begin
            mismatch("colour level", i_red | i_green | i_blue, 255);
        end
        if (vis && i_blue != 0) begin
            blueCnt++;
            if (x < blueMinX) blueMinX = x;
        end
        if (vis && i_green != 0) begin
            greenCnt++;
            if (y < greenMinY) greenMinY = y;
        end
        if (vis && i_red != 0) begin
            redCnt++;
            if (x < redMinX) redMinX = x;
        end
    endtask

    task automatic endFrame();
        if (i_checkEn) begin
            compareVal("state", int'(i_state), i_expState);
            compareVal("blue count", blueCnt, i_expBlue);
            compareVal("green count", greenCnt, i_expGreen);
            compareVal("red count", redCnt, i_expRed);
            compareVal("blue min x", blueMinX, i_expBlueX);
            if (i_expDBlueX != NoDelta && blueMinX - prevBlueX != i_expDBlueX) begin
                mismatch("blue x step", blueMinX - prevBlueX, i_expDBlueX);
            end
            if (i_expDGreenY != NoDelta && greenMinY - prevGreenY != i_expDGreenY) begin
                mismatch("green y step", greenMinY - prevGreenY, i_expDGreenY);
            end
        end
        // Red only shrinks by whole enemies while no bullet is in view
        if (i_huntMode && greenCnt == 0) begin
            if (redCnt % EnemyArea != 0 || redCnt > cleanRed) begin
                mismatch("red drop", redCnt, cleanRed);
            end
            cleanRed = redCnt;
        end
        prevBlueX    = blueMinX;
        prevGreenY   = greenMinY;
        o_blueMinX   <= blueMinX;
        o_redMinX    <= redMinX;
        o_state      <= int'(i_state);
        frames++;
        blueCnt   = 0;
        greenCnt  = 0;
        redCnt    = 0;
        blueMinX  = Far;
        redMinX   = Far;
        greenMinY = Far;
    endtask

    always @(posedge o_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            aligned   = 1'b0;
            x         = 0;
            y         = 0;
            frames    = 0;
            errors    = 0;
            blueCnt   = 0;
            greenCnt  = 0;
            redCnt    = 0;
            blueMinX  = Far;
            redMinX   = Far;
            greenMinY = Far;
            cleanRed  = Far;
        end else begin
            // First visible pixel marks (0, 0)
            if (!aligned && i_blank) begin
                aligned = 1'b1;
            end
            if (aligned) begin
                checkPixel();
                if (x == HDisplay - 1 && y == VDisplay - 1) endFrame();
                x = (x == HTotal - 1) ? 0 : x + 1;
                if (x == 0) y = (y == VTotal - 1) ? 0 : y + 1;
            end
            o_frameCount <= frames;
            o_errors     <= errors;
        end
    end

endmodule

/* tb_valaga.sv */
`timescale 1ns/1ps

module tb_valaga;
    import valagaPkg::*;

    localparam int FrameCycles = 48 * 28;
    localparam int Dc          = -1;
    localparam int NoDelta     = 99;
    localparam int NumRows     = 18;
    localparam int HuntRow     = 14;

    typedef struct {
        logic [3:0] btn;
        int         frames;
        int         state;
        int         blue;
        int         green;
        int         red;
        int         blueX;
        int         dBlueX;
        int         dGreenY;
    } stepRow_t;

    stepRow_t   rows [NumRows];
    logic       o_Clk = 1'b0;
    logic       i_rstN;
    logic [3:0] i_Btn;
    logic [7:0] red, green, blue;
    logic       hsync, vsync, blank;
    logic [1:0] gameState;
    logic       checkEn, huntMode;
    int         expState, expBlue, expGreen, expRed, expBlueX, expDBlueX, expDGreenY;
    int         frameCount, errors, obsBlueX, obsRedMinX, obsState;
    bit         timedOut, huntFailed, reached;

    always #50 o_Clk = ~o_Clk;

    valagaTop #(
        .HDisplay(40), .HSyncStart(42), .HSyncEnd(44), .HTotal(48),
        .VDisplay(24), .VSyncStart(25), .VSyncEnd(26), .VTotal(28),
        .PlayerW(4), .PlayerH(2), .PlayerY(20), .PlayerSpeed(2),
        .BulletW(1), .BulletH(2), .BulletSpeed(2), .MaxBullets(2), .CoolDown(3),
        .EnemyW(4), .EnemyH(2), .EnemyCols(2), .EnemyRows(1), .EnemyGapX(8), .EnemyGapY(4),
        .EnemyOriginX(10), .EnemyOriginY(4), .PhaseLen(4)
    ) valagaTop_i (
        .o_Clk(o_Clk), .i_rstN(i_rstN), .i_Btn(i_Btn),
        .o_Red(red), .o_Green(green), .o_Blue(blue),
        .o_hsync(hsync), .o_vsync(vsync), .o_blank(blank), .o_GameState(gameState)
    );

    valagaChecker #(.EnemyArea(8)) checker_i (
        .o_Clk(o_Clk), .i_rstN(i_rstN), .i_red(red), .i_green(green), .i_blue(blue),
        .i_hsync(hsync), .i_vsync(vsync), .i_blank(blank), .i_state(gameState),
        .i_checkEn(checkEn), .i_huntMode(huntMode), .i_expState(expState),
        .i_expBlue(expBlue), .i_expGreen(expGreen), .i_expRed(expRed),
        .i_expBlueX(expBlueX), .i_expDBlueX(expDBlueX), .i_expDGreenY(expDGreenY),
        .o_frameCount(frameCount), .o_errors(errors), .o_blueMinX(obsBlueX),
        .o_redMinX(obsRedMinX), .o_state(obsState)
    );

    // Active-low buttons in order left, right, fire, start
    task automatic fillTable();
        rows[0]  = '{4'hF, 3, 0, 8, 0, 0, 18, 0, NoDelta};
        rows[1]  = '{4'hE, 1, Dc, Dc, Dc, Dc, Dc, NoDelta, NoDelta};
        rows[2]  = '{4'hF, 2, 1, 8, 0, 16, 18, 0, NoDelta};
        rows[3]  = '{4'h7, 4, 1, 8, 0, 16, Dc, -2, NoDelta};
        rows[4]  = '{4'h7, 10, 1, 8, 0, 16, Dc, NoDelta, NoDelta};
        rows[5]  = '{4'h7, 3, 1, 8, 0, 16, 0, 0, NoDelta};
        rows[6]  = '{4'hB, 4, 1, 8, 0, 16, Dc, 2, NoDelta};
        rows[7]  = '{4'hB, 16, 1, 8, 0, 16, Dc, NoDelta, NoDelta};
        rows[8]  = '{4'hB, 3, 1, 8, 0, 16, 36, 0, NoDelta};
        rows[9]  = '{4'hD, 1, Dc, Dc, Dc, Dc, Dc, NoDelta, NoDelta};
        rows[10] = '{4'hF, 1, Dc, Dc, Dc, Dc, Dc, NoDelta, NoDelta};
        // Second press lands inside the cooldown
        rows[11] = '{4'hD, 1, Dc, Dc, Dc, Dc, Dc, NoDelta, NoDelta};
        rows[12] = '{4'hF, 3, 1, 8, 2, 16, 36, 0, -2};
        rows[13] = '{4'hF, 8, 1, 8, Dc, Dc, 36, 0, NoDelta};
        rows[14] = '{4'hF, 2, 2, 8, Dc, 0, Dc, NoDelta, NoDelta};
        rows[15] = '{4'hE, 1, Dc, Dc, Dc, Dc, Dc, NoDelta, NoDelta};
        rows[16] = '{4'hF, 2, 0, 8, Dc, 0, Dc, NoDelta, NoDelta};
        rows[17] = '{4'hF, 1, Dc, Dc, Dc, Dc, Dc, NoDelta, NoDelta};
    endtask

    task automatic waitFrames(input int n);
        int target;
        int cycles;
        target = frameCount + n;
        cycles = 0;
        while (frameCount < target && cycles < (n + 2) * FrameCycles) begin
            @(posedge o_Clk);
            cycles++;
        end
        if (frameCount < target) begin
            $display("Timeout: no complete frame seen within %0d cycles", cycles);
            timedOut = 1'b1;
        end
    endtask

    task automatic runRow(input int r);
        i_Btn   <= rows[r].btn;
        checkEn <= 1'b0;
        waitFrames(1);
        expState   <= rows[r].state;
        expBlue    <= rows[r].blue;
        expGreen   <= rows[r].green;
        expRed     <= rows[r].red;
        expBlueX   <= rows[r].blueX;
        expDBlueX  <= rows[r].dBlueX;
        expDGreenY <= rows[r].dGreenY;
        checkEn    <= (rows[r].frames > 1);
        if (rows[r].frames > 1 && !timedOut) waitFrames(rows[r].frames - 1);
        $display("Step %0d: buttons %h for %0d frames, errors so far %0d",
                 r, rows[r].btn, rows[r].frames, errors);
    endtask

    // Steer under the lowest red x and keep firing
    task automatic huntEnemies();
        logic goLeft;
        logic goRight;
        logic fire;
        reached = 1'b0;
        huntMode <= 1'b1;
        checkEn  <= 1'b0;
        for (int n = 0; n < 400 && !reached && !timedOut; n++) begin
            if (obsState == int'(GameVictory)) begin
                reached = 1'b1;
            end else begin
                goLeft  = obsBlueX > obsRedMinX + 1;
                goRight = obsBlueX + 1 < obsRedMinX;
                fire    = (n % 2 == 0);
                i_Btn <= {!goLeft, !goRight, !fire, 1'b1};
                waitFrames(1);
            end
        end
        huntMode <= 1'b0;
        $display("Hunt finished, victory %0s, errors so far %0d", reached ? "seen" : "missing",
                 errors);
    endtask

    initial begin
        i_rstN     = 1'b0;
        i_Btn      = 4'hF;
        checkEn    = 1'b0;
        huntMode   = 1'b0;
        expState   = Dc;
        expBlue    = Dc;
        expGreen   = Dc;
        expRed     = Dc;
        expBlueX   = Dc;
        expDBlueX  = NoDelta;
        expDGreenY = NoDelta;
        timedOut   = 1'b0;
        huntFailed = 1'b0;
        fillTable();
        repeat (2) @(posedge o_Clk);
        i_rstN <= 1'b1;
        for (int r = 0; r < NumRows && !timedOut; r++) begin
            if (r == HuntRow) begin
                huntEnemies();
                if (!reached && !timedOut) begin
                    $display("Victory was not reached within the frame limit");
                    huntFailed = 1'b1;
                end
            end
            if (!timedOut) runRow(r);
        end
        @(posedge o_Clk);
        $display("Frames checked %0d, errors %0d", frameCount, errors);
        if (errors == 0 && !timedOut && !huntFailed) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
valagaPkg.sv
objectIf.sv
vgaTiming.sv
buttonConditioner.sv
gameControl.sv
playerUnit.sv
enemyFormation.sv
hitDetect.sv
pixelRenderer.sv
valagaTop.sv
valagaChecker.sv
tb_valaga.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing -Wno-fatal
TOP      ?= tb_valaga
FILELIST ?= all.f
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
